// File: verilog/ingress_bus_pkg.sv
/* Datapath sizes and bus word types. All ingress ports are 8 bits wide and
   packets are at most MAX_PKT_BYTES long. */

package ingress_bus_pkg;

    ////////////////////////////////////////
    // Datapath sizes

    localparam int NUM_PORTS     = 4;
    localparam int PORT_IDX_W    = 2;
    localparam int WORD_BYTES    = 4;
    localparam int MAX_PKT_BYTES = 64;
    localparam int MAX_PKT_WORDS = MAX_PKT_BYTES / WORD_BYTES;
    localparam int FIFO_DEPTH    = 32;
    // Wide enough to hold FIFO_DEPTH itself
    localparam int FIFO_CNT_W    = 6;

    ////////////////////////////////////////
    // Beat and word formats

    // One ingress byte, single-cycle strobe
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] data;
    } port_beat_t;

    // Word held in a port FIFO, lane 0 in bits 7:0
    typedef struct packed {
        logic                      last;
        logic [WORD_BYTES-1:0]     keep;
        logic [WORD_BYTES*8-1:0]   data;
    } fifo_word_t;

    // Converged output word, port carries the source index
    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic [WORD_BYTES-1:0]     keep;
        logic [PORT_IDX_W-1:0]     port;
        logic [WORD_BYTES*8-1:0]   data;
    } bus_word_t;

endpackage

// File: verilog/ingress_csr_pkg.sv
/* Frame counter types and arbiter state encoding. Counters wrap silently. */

package ingress_csr_pkg;

    localparam int CNT_W = 16;

    typedef logic [CNT_W-1:0] frame_cnt_t;

    // One counter per ingress port
    typedef frame_cnt_t [ingress_bus_pkg::NUM_PORTS-1:0] frame_cnts_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_SEND
    } arb_state_e;

endpackage

// File: verilog/byte_packer.sv
/* Packs ingress bytes into FIFO words. A packet is admitted only when its port
   is enabled and the FIFO has room for a maximum-size packet. */

`timescale 1ns/100ps

module byte_packer (
    input  logic                                   core_clk_ifc,
    input  logic                                   rst_n,
    input  ingress_bus_pkg::port_beat_t            beat,
    input  logic                                   enable,
    input  logic [ingress_bus_pkg::FIFO_CNT_W-1:0] free_words,
    output logic                                   wr,
    output ingress_bus_pkg::fifo_word_t            wr_word,
    output logic                                   pkt_done,
    output logic                                   drop
);

    import ingress_bus_pkg::*;

    logic                        in_pkt;
    logic                        accepted;
    logic [1:0]                  lane_cnt;
    logic [WORD_BYTES*8-1:0]     lane_data;
    logic [WORD_BYTES-1:0]       lane_keep;
    logic [WORD_BYTES*8-1:0]     lane_data_nxt;
    logic [WORD_BYTES-1:0]       lane_keep_nxt;
    logic [FIFO_CNT_W-1:0]       free_eff;
    logic                        space_ok;
    logic                        admit;
    logic                        take;
    logic                        word_done;

    // The word written this cycle is not yet counted by the FIFO
    assign free_eff = free_words - FIFO_CNT_W'(wr);
    assign space_ok = free_eff >= FIFO_CNT_W'(MAX_PKT_WORDS);
    assign admit    = enable && space_ok;

    // Decision is taken on the first beat and held for the rest
    assign take      = in_pkt ? accepted : admit;
    assign word_done = beat.last || (lane_cnt == 2'd3);

    always_comb begin
        lane_data_nxt = lane_data;
        lane_keep_nxt = lane_keep;
        lane_data_nxt[lane_cnt*8 +: 8] = beat.data;
        lane_keep_nxt[lane_cnt]        = 1'b1;
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            in_pkt    <= 1'b0;
            accepted  <= 1'b0;
            lane_cnt  <= '0;
            lane_data <= '0;
            lane_keep <= '0;
            wr        <= 1'b0;
            pkt_done  <= 1'b0;
            drop      <= 1'b0;
        end else begin
            wr       <= 1'b0;
            pkt_done <= 1'b0;
            drop     <= 1'b0;
            if (beat.valid) begin
                in_pkt <= !beat.last;
                if (!in_pkt) begin
                    accepted <= admit;
                    // Disabled ports refuse quietly
                    drop     <= enable && !space_ok;
                end
                if (take) begin
                    if (word_done) begin
                        wr        <= 1'b1;
                        pkt_done  <= beat.last;
                        lane_cnt  <= '0;
                        lane_data <= '0;
                        lane_keep <= '0;
                    end else begin
                        lane_cnt  <= lane_cnt + 2'd1;
                        lane_data <= lane_data_nxt;
                        lane_keep <= lane_keep_nxt;
                    end
                end
            end
        end
    end

    // Word payload, unused lanes are already zero
    always_ff @(posedge core_clk_ifc) begin
        if (beat.valid && take && word_done) begin
            wr_word.last <= beat.last;
            wr_word.keep <= lane_keep_nxt;
            wr_word.data <= lane_data_nxt;
        end
    end

endmodule

// File: verilog/port_fifo.sv
/* Word FIFO for one port. The writer must never push into a full FIFO and the
   reader only pops while pkt_avail is set. */

`timescale 1ns/100ps

module port_fifo (
    input  logic                                   core_clk_ifc,
    input  logic                                   rst_n,
    input  logic                                   wr,
    input  ingress_bus_pkg::fifo_word_t            wr_word,
    input  logic                                   rd,
    output ingress_bus_pkg::fifo_word_t            head,
    output logic [ingress_bus_pkg::FIFO_CNT_W-1:0] free_words,
    output logic                                   pkt_avail
);

    import ingress_bus_pkg::*;

    fifo_word_t              mem [FIFO_DEPTH];
    // Pointers wrap naturally at FIFO_DEPTH
    logic [FIFO_CNT_W-2:0]   wr_ptr;
    logic [FIFO_CNT_W-2:0]   rd_ptr;
    logic [FIFO_CNT_W-1:0]   count;
    logic [FIFO_CNT_W-1:0]   pkt_cnt;
    logic                    pkt_in;
    logic                    pkt_out;

    assign head       = mem[rd_ptr];
    assign free_words = FIFO_CNT_W'(FIFO_DEPTH) - count;
    assign pkt_avail  = pkt_cnt != '0;

    assign pkt_in  = wr && wr_word.last;
    assign pkt_out = rd && head.last;

    always_ff @(posedge core_clk_ifc) begin
        if (wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            pkt_cnt <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FIFO_CNT_W'(wr) - FIFO_CNT_W'(rd);
            // Complete packets held
            pkt_cnt <= pkt_cnt + FIFO_CNT_W'(pkt_in) - FIFO_CNT_W'(pkt_out);
        end
    end

endmodule

// File: verilog/rr_packet_arbiter.sv
/* Round-robin arbiter moving whole packets onto the output bus. There is no
   output back-pressure and one idle cycle separates packets. */

`timescale 1ns/100ps

module rr_packet_arbiter (
    input  logic                                                        core_clk_ifc,
    input  logic                                                        rst_n,
    input  logic [ingress_bus_pkg::NUM_PORTS-1:0]                       pkt_avail,
    input  ingress_bus_pkg::fifo_word_t [ingress_bus_pkg::NUM_PORTS-1:0] head,
    output logic [ingress_bus_pkg::NUM_PORTS-1:0]                       rd,
    output ingress_bus_pkg::bus_word_t                                  out
);

    import ingress_bus_pkg::*;
    import ingress_csr_pkg::*;

    arb_state_e              state;
    logic [PORT_IDX_W-1:0]   grant;
    logic [PORT_IDX_W-1:0]   next_port;
    logic [PORT_IDX_W-1:0]   cand;
    logic                    found;
    fifo_word_t              sel_word;

    ////////////////////////////////////////
    // Next requester after the last grant

    always_comb begin
        found     = 1'b0;
        next_port = grant;
        cand      = grant;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = PORT_IDX_W'(grant + i);
            if (!found && pkt_avail[cand]) begin
                found     = 1'b1;
                next_port = cand;
            end
        end
    end

    assign sel_word = head[grant];

    // Pop the granted FIFO every SEND cycle
    always_comb begin
        rd = '0;
        if (state == ARB_SEND) begin
            rd[grant] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // State and output register

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            // Search starts one past this, so port 0 goes first
            grant <= PORT_IDX_W'(NUM_PORTS - 1);
            out   <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    out.valid <= 1'b0;
                    if (found) begin
                        grant <= next_port;
                        state <= ARB_SEND;
                    end
                end
                ARB_SEND: begin
                    out.valid <= 1'b1;
                    out.last  <= sel_word.last;
                    out.keep  <= sel_word.keep;
                    out.port  <= grant;
                    out.data  <= sel_word.data;
                    if (sel_word.last) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/ingress_port_stats.sv
/* Per-port frame counters. Clear wins over a coinciding increment. */

`timescale 1ns/100ps

module ingress_port_stats (
    input  logic                                 core_clk_ifc,
    input  logic                                 rst_n,
    input  logic [ingress_bus_pkg::NUM_PORTS-1:0] pkt_done,
    input  logic [ingress_bus_pkg::NUM_PORTS-1:0] clear,
    output ingress_csr_pkg::frame_cnts_t          frame_cnts
);

    import ingress_bus_pkg::*;
    import ingress_csr_pkg::*;

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            frame_cnts <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (clear[p]) begin
                    frame_cnts[p] <= '0;
                end else if (pkt_done[p]) begin
                    frame_cnts[p] <= frame_cnts[p] + CNT_W'(1);
                end
            end
        end
    end

endmodule

// File: verilog/ingress_top.sv
/* Four-port ingress aggregator, single clock. Drop pulses only when a FIFO
   lacks room for a maximum-size packet. */

`timescale 1ns/100ps

module ingress_top (
    input  logic                                                         core_clk_ifc,
    input  logic                                                         rst_n,
    input  ingress_bus_pkg::port_beat_t [ingress_bus_pkg::NUM_PORTS-1:0] beat,
    input  logic [ingress_bus_pkg::NUM_PORTS-1:0]                        enable,
    input  logic [ingress_bus_pkg::NUM_PORTS-1:0]                        clear,
    output ingress_bus_pkg::bus_word_t                                   out,
    output ingress_csr_pkg::frame_cnts_t                                 frame_cnts,
    output logic [ingress_bus_pkg::NUM_PORTS-1:0]                        drop
);

    import ingress_bus_pkg::*;
    import ingress_csr_pkg::*;

    fifo_word_t [NUM_PORTS-1:0]  wr_word;
    fifo_word_t [NUM_PORTS-1:0]  head;
    logic [NUM_PORTS-1:0]        wr;
    logic [NUM_PORTS-1:0]        rd;
    logic [NUM_PORTS-1:0]        pkt_done;
    logic [NUM_PORTS-1:0]        pkt_avail;
    logic [FIFO_CNT_W-1:0]       free_words [NUM_PORTS];

    ////////////////////////////////////////
    // Per-port packer and buffer

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        byte_packer u_packer (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .beat         (beat[p]),
            .enable       (enable[p]),
            .free_words   (free_words[p]),
            .wr           (wr[p]),
            .wr_word      (wr_word[p]),
            .pkt_done     (pkt_done[p]),
            .drop         (drop[p])
        );

        port_fifo u_fifo (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .wr           (wr[p]),
            .wr_word      (wr_word[p]),
            .rd           (rd[p]),
            .head         (head[p]),
            .free_words   (free_words[p]),
            .pkt_avail    (pkt_avail[p])
        );
    end

    rr_packet_arbiter u_arb (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .pkt_avail    (pkt_avail),
        .head         (head),
        .rd           (rd),
        .out          (out)
    );

    // Counts admitted packets, beside the datapath
    ingress_port_stats u_stats (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .pkt_done     (pkt_done),
        .clear        (clear),
        .frame_cnts   (frame_cnts)
    );

endmodule

// File: verif/ingress_chk.sv
/* Output framing and drop checks, bound into ingress_top. Assumes traffic
   spaced so that no FIFO ever runs short of room, so drop stays low. */

`timescale 1ns/100ps

module ingress_chk (
    input logic                                   core_clk_ifc,
    input logic                                   rst_n,
    input ingress_bus_pkg::bus_word_t             out,
    input logic [ingress_bus_pkg::NUM_PORTS-1:0]  drop
);

    int err_cnt = 0;

    last_keep_nonzero: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out.valid && out.last |-> out.keep != '0)
    else begin
        $error("Final output word has an empty keep mask");
        err_cnt++;
    end

    // Only the final word of a packet may be partial
    mid_keep_full: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out.valid && !out.last |-> out.keep == '1)
    else begin
        $error("Non-final output word has a partial keep mask");
        err_cnt++;
    end

    no_drop: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        drop == '0)
    else begin
        $error("Drop strobe pulsed although every FIFO had room");
        err_cnt++;
    end

    // Source tag holds until the final word
    port_held: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out.valid && !out.last |=> out.valid && out.port == $past(out.port))
    else begin
        $error("Port tag changed or packet broke off before its final word");
        err_cnt++;
    end

endmodule

bind ingress_top ingress_chk chk0 (
    .core_clk_ifc (core_clk_ifc),
    .rst_n        (rst_n),
    .out          (out),
    .drop         (drop)
);

// File: verif/ingress_tb.sv
/* Testbench for the four-port ingress aggregator. Run from the project root so
   that verif/ingress_patterns.txt is found. */

`timescale 1ns/100ps

module ingress_tb;

    import ingress_bus_pkg::*;
    import ingress_csr_pkg::*;

    localparam int MAX_LINES = 64;

    logic                        core_clk_ifc;
    logic                        rst_n;
    port_beat_t [NUM_PORTS-1:0]  beat;
    logic [NUM_PORTS-1:0]        enable;
    logic [NUM_PORTS-1:0]        clear;
    bus_word_t                   out;
    frame_cnts_t                 frame_cnts;
    logic [NUM_PORTS-1:0]        drop;

    // One entry per pattern file line
    logic [8*8-1:0]   kind_a [MAX_LINES];
    logic [8*16-1:0]  name_a [MAX_LINES];
    int               port_a [MAX_LINES];
    int               len_a  [MAX_LINES];
    logic [3:0]       mask_a [MAX_LINES];
    int               clr_a  [MAX_LINES];
    int               cnt_a  [MAX_LINES][NUM_PORTS];
    int               n_lines;

    // Expected traffic per port in arrival order
    logic [7:0]       exp_bytes [NUM_PORTS][$];
    int               exp_lens  [NUM_PORTS][$];

    logic [8*16-1:0]             cur_name;
    port_beat_t [NUM_PORTS-1:0]  beat_nxt;
    logic [NUM_PORTS-1:0]        en_nxt;
    int                          seed;
    int                          cycle_cnt;
    int                          cycle_limit = 0;
    bit                          mon_busy = 1'b0;
    int                          mon_port;
    int                          mon_rem;

    ingress_top dut0 (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .beat         (beat),
        .enable       (enable),
        .clear        (clear),
        .out          (out),
        .frame_cnts   (frame_cnts),
        .drop         (drop)
    );

    initial begin : clock_gen
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////
    // Error reporting

    task automatic report_error(input string msg);
        $display("Error in test %0s: %0s", cur_name, msg);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch in test %0s, %0s: expected %0h, actual %0h",
                 cur_name, what, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    ////////////////////////////////////////
    // Pattern file reader

    task automatic read_patterns();
        int              fd;
        int              n;
        string           line;
        logic [8*8-1:0]  kind;
        fd = $fopen("verif/ingress_patterns.txt", "r");
        assert (fd != 0) else report_error("Cannot open verif/ingress_patterns.txt");
        n_lines = 0;
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s", kind);
            if (n < 1 || line.getc(0) == "#") begin
                continue;
            end
            assert (n_lines < MAX_LINES) else report_error("Pattern file has too many lines");
            kind_a[n_lines] = kind;
            if (kind == "end") begin
                n = $sscanf(line, "%s %s %d %d %d %d", kind, name_a[n_lines],
                            cnt_a[n_lines][0], cnt_a[n_lines][1],
                            cnt_a[n_lines][2], cnt_a[n_lines][3]);
                assert (n == 6) else report_error("Malformed end line in pattern file");
            end else begin
                n = $sscanf(line, "%s %s %d %d %h %d", kind, name_a[n_lines],
                            port_a[n_lines], len_a[n_lines], mask_a[n_lines],
                            clr_a[n_lines]);
                assert (n == 6 && len_a[n_lines] >= 1 && len_a[n_lines] <= MAX_PKT_BYTES)
                    else report_error("Malformed packet line in pattern file");
            end
            n_lines++;
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // Stimulus

    task automatic drive_beat(input int p, input int li, input int k);
        logic [7:0] b;
        bit         take;
        b    = 8'($random(seed));
        take = mask_a[li][p];
        if (k == 0) begin
            en_nxt[p] = take;
            if (take) begin
                exp_lens[p].push_back(len_a[li]);
            end
        end else if (k == len_a[li] / 2) begin
            // Mid-packet flip must not change the outcome
            en_nxt[p] = !take;
        end
        beat_nxt[p].valid = 1'b1;
        beat_nxt[p].last  = (k == len_a[li] - 1);
        beat_nxt[p].data  = b;
        if (take) begin
            exp_bytes[p].push_back(b);
        end
    endtask

    function automatic bit traffic_pending();
        bit busy;
        busy = mon_busy;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_lens[p].size() != 0 || exp_bytes[p].size() != 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // Ports run side by side with each port's packets in file order
    task automatic run_test(input int first, input int end_idx);
        int                    pq [NUM_PORTS][$];
        int                    cur [NUM_PORTS];
        int                    pos [NUM_PORTS];
        logic [NUM_PORTS-1:0]  clr_mask;
        bit                    busy;
        int                    c;
        cur_name = name_a[end_idx];
        clr_mask = '0;
        for (int i = first; i < end_idx; i++) begin
            pq[port_a[i]].push_back(i);
            if (clr_a[i] != 0) begin
                clr_mask[port_a[i]] = 1'b1;
            end
        end
        if (clr_mask != '0) begin
            @(posedge core_clk_ifc);
            clear <= clr_mask;
            @(posedge core_clk_ifc);
            clear <= '0;
            @(negedge core_clk_ifc);
            // Uncleared ports keep the counts of the previous test
            for (int p = 0; p < NUM_PORTS; p++) begin
                c = (clr_mask[p] || first == 0) ? 0 : cnt_a[first - 1][p];
                assert (frame_cnts[p] == CNT_W'(c))
                    else report_mismatch($sformatf("port %0d count after clear", p),
                                         c, frame_cnts[p]);
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            cur[p] = -1;
        end
        busy = 1'b1;
        while (busy) begin
            @(posedge core_clk_ifc);
            busy     = 1'b0;
            beat_nxt = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cur[p] < 0 && pq[p].size() > 0) begin
                    cur[p] = pq[p].pop_front();
                    pos[p] = 0;
                end
                // About one idle cycle in four
                if (cur[p] >= 0) begin
                    busy = 1'b1;
                    if (($random(seed) & 3) != 0) begin
                        drive_beat(p, cur[p], pos[p]);
                        pos[p]++;
                        if (pos[p] == len_a[cur[p]]) begin
                            cur[p] = -1;
                        end
                    end
                end
            end
            beat   <= beat_nxt;
            enable <= en_nxt;
        end
        while (traffic_pending()) begin
            @(negedge core_clk_ifc);
        end
        // Long enough for a wrongly admitted packet to show up
        repeat (20) @(negedge core_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (frame_cnts[p] == CNT_W'(cnt_a[end_idx][p]))
                else report_mismatch($sformatf("port %0d frame count", p),
                                     cnt_a[end_idx][p], frame_cnts[p]);
        end
    endtask

    ////////////////////////////////////////
    // Output scoreboard

    task automatic check_word();
        logic [7:0] exp_b;
        bit         exp_last;
        if (!out.valid) begin
            assert (!mon_busy) else report_error("Output packet broken by an idle cycle");
        end else begin
            if (!mon_busy) begin
                mon_port = int'(out.port);
                assert (exp_lens[mon_port].size() > 0)
                    else report_error($sformatf("Unexpected packet from port %0d", mon_port));
                mon_rem  = exp_lens[mon_port].pop_front();
                mon_busy = 1'b1;
            end
            assert (int'(out.port) == mon_port)
                else report_mismatch("port tag", mon_port, out.port);
            for (int l = 0; l < WORD_BYTES; l++) begin
                exp_b = (l < mon_rem) ? exp_bytes[mon_port].pop_front() : 8'h00;
                assert (out.keep[l] == (l < mon_rem))
                    else report_mismatch($sformatf("keep lane %0d", l), l < mon_rem,
                                         out.keep[l]);
                assert (out.data[l*8 +: 8] == exp_b)
                    else report_mismatch($sformatf("data lane %0d of port %0d", l, mon_port),
                                         exp_b, out.data[l*8 +: 8]);
            end
            exp_last = (mon_rem <= WORD_BYTES);
            assert (out.last == exp_last) else report_mismatch("last flag", exp_last, out.last);
            mon_rem  = mon_rem - WORD_BYTES;
            mon_busy = !exp_last;
        end
    endtask

    initial begin : monitor
        forever begin
            @(negedge core_clk_ifc);
            if (rst_n) begin
                check_word();
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        forever begin
            @(posedge core_clk_ifc);
            cycle_cnt++;
            assert (cycle_limit == 0 || cycle_cnt <= cycle_limit)
                else report_error("Timeout, the run exceeded its cycle limit");
            assert (dut0.chk0.err_cnt == 0)
                else report_error("A bound assertion on the output bus or drop failed");
        end
    end

    initial begin : main
        int first;
        int total_bytes;
        seed     = 32'hf81d_3c3b;
        cur_name = "setup";
        rst_n    = 1'b0;
        beat     = '0;
        enable   = '0;
        clear    = '0;
        beat_nxt = '0;
        en_nxt   = '0;
        read_patterns();
        total_bytes = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (kind_a[i] != "end") begin
                total_bytes += len_a[i];
            end
        end
        cycle_limit = total_bytes * 8 + 1000;
        repeat (5) @(posedge core_clk_ifc);
        rst_n <= 1'b1;
        first = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (kind_a[i] == "end") begin
                run_test(first, i);
                first = i + 1;
            end
        end
        cur_name = "final";
        repeat (4) @(posedge core_clk_ifc);
        if (dut0.chk0.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/ingress_patterns.txt
# pkt <test> <port> <length in bytes> <enable mask, hex> <clear port before test>
# end <test> <expected frame count of port 0> <port 1> <port 2> <port 3>
pkt turn0 0 1 f 0
pkt turn0 0 6 f 0
end turn0 2 0 0 0
pkt turn1 1 4 f 0
pkt turn1 1 13 f 0
end turn1 2 2 0 0
pkt turn2 2 33 f 0
end turn2 2 2 1 0
pkt turn3 3 64 f 0
end turn3 2 2 1 1
pkt burst 0 64 f 0
pkt burst 1 61 f 0
pkt burst 2 30 f 0
pkt burst 3 64 f 0
pkt burst 0 2 f 0
end burst 4 3 2 2
pkt disable 2 20 b 0
pkt disable 1 40 f 0
pkt disable 2 9 f 0
end disable 4 4 3 2
pkt clear 3 17 f 1
pkt clear 0 3 e 0
end clear 4 4 3 1

// File: filelist.f
verilog/ingress_bus_pkg.sv
verilog/ingress_csr_pkg.sv
verilog/byte_packer.sv
verilog/port_fifo.sv
verilog/rr_packet_arbiter.sv
verilog/ingress_port_stats.sv
verilog/ingress_top.sv
verif/ingress_chk.sv
verif/ingress_tb.sv

// File: Bender.yml
package:
  name: ingress_aggregator

sources:
  # Packages ahead of the modules that import them
  - verilog/ingress_bus_pkg.sv
  - verilog/ingress_csr_pkg.sv
  - verilog/byte_packer.sv
  - verilog/port_fifo.sv
  - verilog/rr_packet_arbiter.sv
  - verilog/ingress_port_stats.sv
  - verilog/ingress_top.sv
  - target: simulation
    files:
      - verif/ingress_chk.sv
      - verif/ingress_tb.sv
